/* common/noc_pkg.sv */
package noc_pkg;

  localparam int NUM_PORTS = 4;

  // every output port arbitrates among all inputs except its own
  localparam int NUM_CAND = NUM_PORTS - 1;

  typedef logic [15:0] flit_t;
  typedef logic [7:0]  node_addr_t;
  typedef logic [7:0]  flit_len_t;
  typedef logic [1:0]  port_idx_t;
  typedef logic [NUM_CAND-1:0] grant_t;

  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  typedef enum logic [2:0] {
    DIR_N,
    DIR_S,
    DIR_E,
    DIR_W,
    DIR_LOCAL
  } dir_e;

  // names the side of the mesh where this node has no neighbour
  typedef enum logic [1:0] {
    EDGE_TOP,
    EDGE_BOTTOM,
    EDGE_RIGHT,
    EDGE_LEFT
  } edge_e;

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  // north is the larger Y, east the larger X
  function automatic edge_e edge_of_node(int node_x, int node_y, int mesh_w, int mesh_h);
    if (node_y == mesh_h - 1) begin
      return EDGE_TOP;
    end else if (node_y == 0) begin
      return EDGE_BOTTOM;
    end else if (node_x == mesh_w - 1) begin
      return EDGE_RIGHT;
    end
    return EDGE_LEFT;
  endfunction

  // on top and bottom nodes port 0 is the vertical neighbour, then east and west;
  // on right and left nodes it is north, south, then the horizontal neighbour
  function automatic port_idx_t port_of_dir(dir_e dir, edge_e node_edge);
    if (dir == DIR_LOCAL) begin
      return port_idx_t'(3);
    end
    if (node_edge == EDGE_TOP || node_edge == EDGE_BOTTOM) begin
      case (dir)
        DIR_E:   return port_idx_t'(1);
        DIR_W:   return port_idx_t'(2);
        default: return port_idx_t'(0);
      endcase
    end
    case (dir)
      DIR_N:   return port_idx_t'(0);
      DIR_S:   return port_idx_t'(1);
      default: return port_idx_t'(2);
    endcase
  endfunction

  // input port seen as candidate k by output port out_port
  function automatic int cand_port(int out_port, int k);
    return (k < out_port) ? k : k + 1;
  endfunction

endpackage

/* verilog/flit_fifo.sv */
module flit_fifo
  import noc_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  push_i,
  input  flit_t push_flit_i,
  input  logic  pop_i,
  output flit_t head_flit_o,
  output logic  head_valid_o,
  output logic  full_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  flit_t mem_q [FIFO_DEPTH];
  ptr_t  rd_ptr_q;
  ptr_t  wr_ptr_q;
  cnt_t  count_q;
  logic  do_push;
  logic  do_pop;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o       = (count_q == cnt_t'(FIFO_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_flit_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // a push and a pop in the same cycle leave the count as it is
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* verilog/flit_tracker.sv */
module flit_tracker
  import noc_pkg::*;
#(
  parameter int NODE_X = 4,
  parameter int NODE_Y = 4,
  parameter int MESH_W = 4,
  parameter int MESH_H = 4
)
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  flit_t     head_flit_i,
  input  logic      head_valid_i,
  input  logic      pop_i,
  output logic      req_o,
  output port_idx_t req_port_o,
  output logic      last_o
);

  localparam edge_e      NODE_EDGE  = edge_of_node(NODE_X, NODE_Y, MESH_W, MESH_H);
  localparam node_addr_t LOCAL_ADDR = node_addr_t'(NODE_Y * 16 + NODE_X);

  flit_len_t  remaining_q;
  port_idx_t  held_port_q;
  logic       is_header;
  node_addr_t dest_addr;
  flit_len_t  head_len;
  dir_e       route_dir;
  port_idx_t  route_port;

  // nothing left of the previous packet means the head flit starts a new one
  assign is_header = (remaining_q == '0);
  assign dest_addr = head_flit_i[7:0];
  assign head_len  = head_flit_i[15:8];

  // dimension order routing, X is resolved before Y
  always_comb begin
    if (dest_addr[3:0] < LOCAL_ADDR[3:0]) begin
      route_dir = DIR_W;
    end else if (dest_addr[3:0] > LOCAL_ADDR[3:0]) begin
      route_dir = DIR_E;
    end else if (dest_addr[7:4] < LOCAL_ADDR[7:4]) begin
      route_dir = DIR_S;
    end else if (dest_addr[7:4] > LOCAL_ADDR[7:4]) begin
      route_dir = DIR_N;
    end else begin
      route_dir = DIR_LOCAL;
    end
  end

  assign route_port = port_of_dir(route_dir, NODE_EDGE);

  assign req_o      = head_valid_i;
  assign req_port_o = is_header ? route_port : held_port_q;

  // a length of zero is handled as a single flit packet
  assign last_o = head_valid_i &&
                  (is_header ? (head_len <= flit_len_t'(1)) : (remaining_q == flit_len_t'(1)));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remaining_q <= '0;
    end else if (pop_i) begin
      if (is_header) begin
        remaining_q <= (head_len > flit_len_t'(1)) ? head_len - flit_len_t'(1) : '0;
      end else begin
        remaining_q <= remaining_q - flit_len_t'(1);
      end
    end
  end

  // body flits follow the port their header was routed to
  always_ff @(posedge clk_i) begin
    if (pop_i && is_header) begin
      held_port_q <= route_port;
    end
  end

endmodule

/* output_port/output_port.sv */
module output_port
  import noc_pkg::*;
#(
  parameter int OUT_PORT = 0
)
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic  [NUM_CAND-1:0]   req_i,
  input  logic  [NUM_CAND-1:0]   last_i,
  input  flit_t [NUM_CAND-1:0]   cand_flit_i,
  input  logic                   full_i,
  output grant_t                 grant_o,
  output link_t                  link_o
);

  typedef logic [1:0] cand_idx_t;

  arb_state_e state_q;
  arb_state_e state_d;
  cand_idx_t  rr_ptr_q;
  cand_idx_t  rr_ptr_d;
  grant_t     owner_q;
  grant_t     owner_d;
  grant_t     rr_pick;
  logic       grant_last;
  flit_t      sel_flit;
  logic       link_valid_q;
  flit_t      link_flit_q;

  if (OUT_PORT < 0 || OUT_PORT >= NUM_PORTS) begin : g_bad_port
    $error("output_port: OUT_PORT %0d is not a port of the node", OUT_PORT);
  end

  // first requester at or after the pointer, which sits just past the last winner
  function automatic grant_t rr_first(logic [NUM_CAND-1:0] req, cand_idx_t ptr);
    grant_t pick;
    int     idx;
    pick = '0;
    for (int i = NUM_CAND - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % NUM_CAND;
      if (req[idx]) begin
        pick = grant_t'(1) << idx;
      end
    end
    return pick;
  endfunction

  function automatic cand_idx_t ptr_after(grant_t winner);
    cand_idx_t ptr;
    ptr = '0;
    for (int k = 0; k < NUM_CAND; k++) begin
      if (winner[k]) begin
        ptr = cand_idx_t'((k + 1) % NUM_CAND);
      end
    end
    return ptr;
  endfunction

  assign rr_pick = rr_first(req_i, rr_ptr_q);

  always_comb begin
    state_d  = state_q;
    owner_d  = owner_q;
    rr_ptr_d = rr_ptr_q;
    grant_o  = '0;
    case (state_q)
      ARB_IDLE: begin
        if (!full_i) begin
          grant_o = rr_pick;
        end
      end
      ARB_BUSY: begin
        // an empty owner FIFO gives no flit, but the lock stays
        if (!full_i) begin
          grant_o = owner_q & req_i;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
    grant_last = |(grant_o & last_i);
    if (|grant_o) begin
      if (grant_last) begin
        state_d  = ARB_IDLE;
        rr_ptr_d = ptr_after(grant_o);
      end else begin
        state_d = ARB_BUSY;
        owner_d = grant_o;
      end
    end
  end

  always_comb begin
    sel_flit = '0;
    for (int k = 0; k < NUM_CAND; k++) begin
      sel_flit = sel_flit | (cand_flit_i[k] & {$bits(flit_t){grant_o[k]}});
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= ARB_IDLE;
      owner_q      <= '0;
      rr_ptr_q     <= '0;
      link_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      owner_q      <= owner_d;
      rr_ptr_q     <= rr_ptr_d;
      link_valid_q <= |grant_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|grant_o) begin
      link_flit_q <= sel_flit;
    end
  end

  assign link_o.valid = link_valid_q;
  assign link_o.flit  = link_flit_q;

endmodule

/* verilog/node4.sv */
module node4
  import noc_pkg::*;
#(
  parameter int NODE_X     = 4,
  parameter int NODE_Y     = 4,
  parameter int MESH_W     = 4,
  parameter int MESH_H     = 4,
  parameter int FIFO_DEPTH = 4
)
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  link_t     [NUM_PORTS-1:0]    link_i,
  output logic      [NUM_PORTS-1:0]    full_o,
  output link_t     [NUM_PORTS-1:0]    link_o,
  input  logic      [NUM_PORTS-1:0]    full_i
);

  flit_t     [NUM_PORTS-1:0] head_flit;
  logic      [NUM_PORTS-1:0] head_valid;
  logic      [NUM_PORTS-1:0] req;
  port_idx_t [NUM_PORTS-1:0] req_port;
  logic      [NUM_PORTS-1:0] last;
  logic      [NUM_PORTS-1:0] pop;
  grant_t    [NUM_PORTS-1:0] grant;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    flit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .push_i       (link_i[p].valid),
      .push_flit_i  (link_i[p].flit),
      .pop_i        (pop[p]),
      .head_flit_o  (head_flit[p]),
      .head_valid_o (head_valid[p]),
      .full_o       (full_o[p])
    );

    flit_tracker #(
      .NODE_X (NODE_X),
      .NODE_Y (NODE_Y),
      .MESH_W (MESH_W),
      .MESH_H (MESH_H)
    ) u_tracker (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .head_flit_i  (head_flit[p]),
      .head_valid_i (head_valid[p]),
      .pop_i        (pop[p]),
      .req_o        (req[p]),
      .req_port_o   (req_port[p]),
      .last_o       (last[p])
    );
  end

  for (genvar q = 0; q < NUM_PORTS; q++) begin : g_out
    logic  [NUM_CAND-1:0] cand_req;
    logic  [NUM_CAND-1:0] cand_last;
    flit_t [NUM_CAND-1:0] cand_flit;

    // an input only bids for the output its head flit is routed to
    for (genvar k = 0; k < NUM_CAND; k++) begin : g_cand
      localparam int IN = cand_port(q, k);
      assign cand_req[k]  = req[IN] && (req_port[IN] == port_idx_t'(q));
      assign cand_last[k] = last[IN];
      assign cand_flit[k] = head_flit[IN];
    end

    output_port #(
      .OUT_PORT (q)
    ) u_out (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (cand_req),
      .last_i      (cand_last),
      .cand_flit_i (cand_flit),
      .full_i      (full_i[q]),
      .grant_o     (grant[q]),
      .link_o      (link_o[q])
    );
  end

  // at most one output grants a given input, since it requests only one port
  always_comb begin
    pop = '0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int k = 0; k < NUM_CAND; k++) begin
        if (grant[q][k]) begin
          pop[cand_port(q, k)] = 1'b1;
        end
      end
    end
  end

endmodule

/* verif/node4_checker.sv */
module node4_checker
  import noc_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      idle_i,
  input  logic                      done_i,
  input  link_t [NUM_PORTS-1:0]     link_in_i,
  input  logic  [NUM_PORTS-1:0]     in_full_i,
  input  link_t [NUM_PORTS-1:0]     link_out_i,
  input  logic  [NUM_PORTS-1:0]     out_full_i,
  input  logic  [NUM_PORTS-1:0]     full_expect_i,
  input  logic                      exp_push_i,
  input  port_idx_t                 exp_port_i,
  input  port_idx_t                 exp_src_i,
  input  logic  [7:0]               exp_lat_i,
  input  flit_t                     exp_flit_i,
  output int                        err_count_o,
  output logic                      drained_o
);

  // expected flits per output port, in the order they must leave
  flit_t          exp_flit_q [NUM_PORTS][$];
  port_idx_t      exp_src_q  [NUM_PORTS][$];
  logic [7:0]     exp_lat_q  [NUM_PORTS][$];
  int             cyc;
  int             take_cyc [NUM_PORTS];
  logic [NUM_PORTS-1:0] prev_full;
  logic [NUM_PORTS-1:0] full_seen;
  logic           done_seen;
  int             errors;
  flit_t          want_flit;
  port_idx_t      want_src;
  logic [7:0]     want_lat;

  initial begin
    cyc       = 0;
    errors    = 0;
    prev_full = '0;
    full_seen = '0;
    done_seen = 1'b0;
    drained_o = 1'b1;
  end

  assign err_count_o = errors;

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cyc = cyc + 1;
      if (exp_push_i) begin
        exp_flit_q[exp_port_i].push_back(exp_flit_i);
        exp_src_q[exp_port_i].push_back(exp_src_i);
        exp_lat_q[exp_port_i].push_back(exp_lat_i);
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (idle_i && (link_out_i[q].valid || in_full_i[q])) begin
          $display("[FAIL] %0t: port %0d was active before any stimulus", $time, q);
          errors++;
        end
        if (prev_full[q] && link_out_i[q].valid) begin
          $display("[FAIL] %0t: port %0d sent a flit one cycle after full_i was high", $time, q);
          errors++;
        end
        if (link_out_i[q].valid) begin
          if (exp_flit_q[q].size() == 0) begin
            $display("port %0d sent flit %h at time %0t, but no flit was expected there",
                     q, link_out_i[q].flit, $time);
            errors++;
          end else begin
            want_flit = exp_flit_q[q].pop_front();
            want_src  = exp_src_q[q].pop_front();
            want_lat  = exp_lat_q[q].pop_front();
            if (link_out_i[q].flit !== want_flit) begin
              $display("[FAIL] %0t: port %0d sent flit %h, expected %h",
                       $time, q, link_out_i[q].flit, want_flit);
              errors++;
            end
            // a flit taken at one edge is sampled on the output two edges later
            if (want_lat != 0 && cyc - take_cyc[want_src] != int'(want_lat)) begin
              $display("[FAIL] %0t: port %0d latency %0d, expected %0d",
                       $time, q, cyc - take_cyc[want_src], want_lat);
              errors++;
            end
          end
        end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (link_in_i[p].valid) begin
          take_cyc[p] = cyc;
        end
        if (in_full_i[p]) begin
          full_seen[p] = 1'b1;
        end
      end
      prev_full = out_full_i;
      drained_o = 1'b1;
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (exp_flit_q[q].size() != 0) begin
          drained_o = 1'b0;
        end
      end
      if (done_i && !done_seen) begin
        done_seen = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (exp_flit_q[p].size() != 0) begin
            $display("%0d flits never left port %0d", exp_flit_q[p].size(), p);
            errors++;
          end
          if (full_expect_i[p] && !full_seen[p]) begin
            $display("input %0d never raised full_o although it was filled", p);
            errors++;
          end
        end
      end
    end
  end

endmodule

/* verif/node4_tb.sv */
module node4_tb
  import noc_pkg::*;
();

  localparam int NODE_X       = 3;
  localparam int NODE_Y       = 1;
  localparam int FIFO_DEPTH   = 4;
  localparam int NUM_ROWS     = 11;
  localparam int RESET_CYCLES = 16;
  localparam int MARGIN       = 200;
  localparam int DRAIN_LIMIT  = 64;
  // (3,1) in a 4x4 mesh lies on the right side
  localparam edge_e NODE_EDGE = EDGE_RIGHT;

  typedef struct packed {
    port_idx_t   src;
    node_addr_t  dest;
    flit_len_t   len;
    logic [15:0] start;
    logic [7:0]  lat;
    logic [15:0] blk_from;
    logic [7:0]  blk_len;
  } row_t;

  logic                  clk;
  logic                  arst_n;
  link_t [NUM_PORTS-1:0] link_in;
  logic  [NUM_PORTS-1:0] full_o_w;
  link_t [NUM_PORTS-1:0] link_out;
  logic  [NUM_PORTS-1:0] full_i_r;
  logic                  idle;
  logic                  done;
  logic                  exp_push;
  port_idx_t             exp_port;
  port_idx_t             exp_src;
  logic [7:0]            exp_lat;
  flit_t                 exp_flit;
  int                    err_count;
  logic                  drained;
  row_t                  rows [NUM_ROWS];
  int                    cycle_limit;
  int                    cycles;

  node4 #(
    .NODE_X (NODE_X), .NODE_Y (NODE_Y), .MESH_W (4), .MESH_H (4), .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .clk_i (clk), .arst_n_i (arst_n), .link_i (link_in), .full_o (full_o_w),
    .link_o (link_out), .full_i (full_i_r)
  );

  node4_checker chk (
    .clk_i (clk), .arst_n_i (arst_n), .idle_i (idle), .done_i (done),
    .link_in_i (link_in), .in_full_i (full_o_w), .link_out_i (link_out),
    .out_full_i (full_i_r), .full_expect_i (4'b0100), .exp_push_i (exp_push),
    .exp_port_i (exp_port), .exp_src_i (exp_src), .exp_lat_i (exp_lat),
    .exp_flit_i (exp_flit), .err_count_o (err_count), .drained_o (drained)
  );

  always #50 clk = ~clk;

  // X first, then Y, equal address stays local
  function automatic port_idx_t route_port(node_addr_t dest);
    dir_e dir;
    if (int'(dest[3:0]) < NODE_X) dir = DIR_W;
    else if (int'(dest[3:0]) > NODE_X) dir = DIR_E;
    else if (int'(dest[7:4]) < NODE_Y) dir = DIR_S;
    else if (int'(dest[7:4]) > NODE_Y) dir = DIR_N;
    else dir = DIR_LOCAL;
    return port_of_dir(dir, NODE_EDGE);
  endfunction

  // body flits carry the row as a tag and their index in the packet
  function automatic flit_t flit_of(int r, int idx);
    if (idx == 0) return {rows[r].len, rows[r].dest};
    return {8'(8'hA0 + r), 8'(idx)};
  endfunction

  function automatic logic [NUM_PORTS-1:0] blocked_ports(int c);
    logic [NUM_PORTS-1:0] mask;
    mask = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (c >= int'(rows[r].blk_from) && c < int'(rows[r].blk_from) + int'(rows[r].blk_len)) begin
        mask[route_port(rows[r].dest)] = 1'b1;
      end
    end
    return mask;
  endfunction

  task automatic run_stimulus();
    int cur [NUM_PORTS];
    int fidx [NUM_PORTS];
    bit sent [NUM_ROWS];
    int c;
    int left;
    bit found;
    c    = 0;
    left = NUM_ROWS;
    for (int p = 0; p < NUM_PORTS; p++) begin
      cur[p]  = -1;
      fidx[p] = 0;
    end
    while (left > 0) begin
      @(negedge clk);
      full_i_r = blocked_ports(c);
      for (int p = 0; p < NUM_PORTS; p++) begin
        link_in[p] = '0;
        found = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
          if (cur[p] < 0 && !found && !sent[r] && int'(rows[r].src) == p) begin
            found = 1'b1;
            if (int'(rows[r].start) <= c) cur[p] = r;
          end
        end
        if (cur[p] >= 0 && !full_o_w[p]) begin
          link_in[p].valid = 1'b1;
          link_in[p].flit  = flit_of(cur[p], fidx[p]);
          fidx[p]++;
          if (fidx[p] == int'(rows[cur[p]].len)) begin
            sent[cur[p]] = 1'b1;
            cur[p]  = -1;
            fidx[p] = 0;
            left--;
          end
        end
      end
      c++;
    end
    @(negedge clk);
    link_in  = '0;
    full_i_r = '0;
  endtask

  // the expected queues empty out once every flit has left the node
  task automatic wait_drained(int limit);
    int n;
    n = 0;
    while (!drained && n < limit) begin
      @(negedge clk);
      n++;
    end
  endtask

  always @(posedge clk) begin
    if (arst_n) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  initial begin
    rows = '{
      '{2'd3, 8'h10, 8'd1, 16'd0,   8'd2, 16'd0,   8'd0},
      '{2'd2, 8'h33, 8'd4, 16'd10,  8'd0, 16'd0,   8'd0},
      '{2'd0, 8'h03, 8'd3, 16'd20,  8'd0, 16'd0,   8'd0},
      '{2'd1, 8'h13, 8'd2, 16'd30,  8'd0, 16'd0,   8'd0},
      '{2'd0, 8'h13, 8'd1, 16'd40,  8'd2, 16'd0,   8'd0},
      '{2'd0, 8'h21, 8'd3, 16'd60,  8'd0, 16'd0,   8'd0},
      '{2'd1, 8'h01, 8'd3, 16'd60,  8'd0, 16'd0,   8'd0},
      '{2'd0, 8'h22, 8'd3, 16'd60,  8'd0, 16'd0,   8'd0},
      '{2'd1, 8'h02, 8'd3, 16'd60,  8'd0, 16'd0,   8'd0},
      '{2'd3, 8'h23, 8'd5, 16'd100, 8'd0, 16'd102, 8'd6},
      '{2'd2, 8'h03, 8'd7, 16'd120, 8'd0, 16'd119, 8'd15}
    };
    cycles      = 0;
    cycle_limit = MARGIN;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += 2 * int'(rows[r].len) + int'(rows[r].blk_len);
      if (int'(rows[r].start) > cycle_limit - MARGIN) cycle_limit += int'(rows[r].start);
    end
    clk      = 1'b0;
    arst_n   = 1'b0;
    link_in  = '0;
    full_i_r = '0;
    idle     = 1'b1;
    done     = 1'b0;
    exp_push = 1'b0;
    exp_port = '0;
    exp_src  = '0;
    exp_lat  = '0;
    exp_flit = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // load the expected flits while the node sits idle
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < int'(rows[r].len); i++) begin
        @(negedge clk);
        exp_push = 1'b1;
        exp_port = route_port(rows[r].dest);
        exp_src  = rows[r].src;
        exp_lat  = (i == 0) ? rows[r].lat : 8'd0;
        exp_flit = flit_of(r, i);
      end
    end
    @(negedge clk);
    exp_push = 1'b0;
    repeat (4) @(negedge clk);
    idle = 1'b0;
    run_stimulus();
    wait_drained(DRAIN_LIMIT);
    repeat (8) @(negedge clk);
    done = 1'b1;
    repeat (2) @(negedge clk);
    $display("closing summary: %0d errors", err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* noc_node.f */
common/noc_pkg.sv
verilog/flit_fifo.sv
verilog/flit_tracker.sv
output_port/output_port.sv
verilog/node4.sv
verif/node4_checker.sv
verif/node4_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= node4_tb
RTL_TOP   ?= node4
FILELIST  ?= noc_node.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
